// File: list.f
design/bus_pkg.sv
design/uart_reg_pkg.sv
design/sync_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_ctrl.sv
dv/uart_ctrl_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module uart_ctrl_tb \
		-Mdir obj_dir -o uart_ctrl_tb

run: compile
	./obj_dir/uart_ctrl_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/uart_ctrl_tb.sv
`default_nettype none

module uart_ctrl_tb
    import bus_pkg::*;
    import uart_reg_pkg::*;
();

    localparam int WAIT_LIMIT = 5000;

    logic              clk_i;
    logic              rstn_i;
    logic              req_valid_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_data_i;
    logic [OP_W-1:0]   req_op_i;
    logic              req_ready_o;
    logic              rsp_valid_o;
    logic [DATA_W-1:0] rsp_data_o;
    logic [OP_W-1:0]   rsp_op_o;
    logic              rsp_ready_i;
    logic              rx_i;
    logic              tx_o;

    logic        loopback;
    logic        serial_bit;
    logic [31:0] seed;
    int          errors;
    int          timeouts;
    int          baud_div;

    uart_ctrl uart_ctrl_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_op_i    (req_op_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_op_o    (rsp_op_o),
        .rsp_ready_i (rsp_ready_i),
        .rx_i        (rx_i),
        .tx_o        (tx_o)
    );

    assign rx_i = loopback ? tx_o : serial_bit; // The serial model or the DUT's own output.

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_op_o))
    else begin
        errors++;
        $display("FAILED at %0t: response changed while the master stalled it", $time);
    end

    a_no_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
    else begin
        errors++;
        $display("FAILED at %0t: request ready while a response is stalled", $time);
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("FAILED at %0t: %s", $time, msg);
        end
    endtask

    // One complete transfer made of the request handshake and the response taken with ready high.
    task automatic bus_access(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, output logic [OP_W-1:0] rop,
                              output logic [DATA_W-1:0] rdata);
        int n;
        rop   = '1;
        rdata = '0;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= addr;
        req_data_i  <= wdata;
        rsp_ready_i <= 1'b1;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!req_ready_o && n < WAIT_LIMIT);
        req_valid_i <= 1'b0;
        if (!req_ready_o) begin
            timeouts++;
            $display("Timeout: the request to %h was never accepted", addr);
            return;
        end
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!rsp_valid_o && n < WAIT_LIMIT);
        if (!rsp_valid_o) begin
            timeouts++;
            $display("Timeout: no response arrived for the request to %h", addr);
            return;
        end
        rop   = rsp_op_o;
        rdata = rsp_data_o;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [OP_W-1:0]   op;
        logic [DATA_W-1:0] rdata;
        bus_access(OP_PUT_FULL, addr, data, op, rdata);
        expect_true(op == OP_ACK, $sformatf("write to %h answered with opcode %0d", addr, op));
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [OP_W-1:0] op,
                            output logic [DATA_W-1:0] data);
        bus_access(OP_GET, addr, '0, op, data);
    endtask

    // Drives one 8N1 frame on the serial line with the LSB first.
    task automatic send_frame(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_i);
            serial_bit <= frame[i];
            repeat (baud_div - 1) @(posedge clk_i);
        end
        repeat (baud_div) @(posedge clk_i);
    endtask

    task automatic check_tx_frame(input logic [7:0] data);
        logic [9:0] frame;
        int n;
        frame = {1'b1, data, 1'b0};
        n = 0;
        while (tx_o && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (tx_o) begin
            timeouts++;
            $display("Timeout: no start bit appeared on tx_o");
            return;
        end
        repeat (baud_div / 2) @(posedge clk_i); // Middle of the start bit.
        for (int i = 0; i < 10; i++) begin
            expect_true(tx_o == frame[i],
                        $sformatf("tx bit %0d is %b, expected %b", i, tx_o, frame[i]));
            repeat (baud_div) @(posedge clk_i);
        end
    endtask

    task automatic stalled_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] held_data;
        int n;
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= OP_GET;
        req_addr_i  <= addr;
        rsp_ready_i <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!req_ready_o && n < WAIT_LIMIT);
        req_valid_i <= 1'b0;
        if (!req_ready_o) begin
            timeouts++;
            $display("Timeout: the stalled read was never accepted");
            rsp_ready_i <= 1'b1;
            return;
        end
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!rsp_valid_o && n < WAIT_LIMIT);
        if (!rsp_valid_o) begin
            timeouts++;
            $display("Timeout: no response arrived for the stalled read");
            return;
        end
        held_data = rsp_data_o;
        repeat (6) @(posedge clk_i);
        expect_true(rsp_valid_o && rsp_op_o == OP_ERR, "stalled response is not an error");
        expect_true(rsp_data_o == held_data, "stalled response data changed");
        expect_true(!req_ready_o, "request ready during back-pressure");
        rsp_ready_i <= 1'b1;
        @(posedge clk_i);
    endtask

    initial begin
        logic [OP_W-1:0]   op;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] ctrl_word;
        logic [7:0]        byte_q[$];
        logic [7:0]        sent;
        logic [7:0]        expected;
        seed     = 32'd10;
        errors   = 0;
        timeouts = 0;
        baud_div = 4;
        rstn_i      <= 1'b0;
        req_valid_i <= 1'b0;
        req_addr_i  <= '0;
        req_data_i  <= '0;
        req_op_i    <= OP_GET;
        rsp_ready_i <= 1'b1;
        loopback    <= 1'b0;
        serial_bit  <= 1'b1; // Line idles high.
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        expect_true(tx_o && !rsp_valid_o, "outputs are wrong after reset");
        bus_read(UART_BASE + REG_STATUS, op, data);
        expect_true(op == OP_ACK_DATA && data == ((32'd1 << ST_TX_EMPTY) | (32'd1 << ST_RX_EMPTY)),
                    $sformatf("STATUS after reset is %h with opcode %0d", data, op));
        bus_read(UART_BASE + REG_CTRL, op, data);
        expect_true(op == OP_ACK_DATA && data == '0, $sformatf("CTRL after reset is %h", data));

        baud_div  = 4 + int'((next_random() >> 16) % 12);
        ctrl_word = {16'(baud_div), 14'd0, 1'b1, 1'b1};
        bus_write(UART_BASE + REG_CTRL, ctrl_word);
        bus_read(UART_BASE + REG_CTRL, op, data);
        expect_true(op == OP_ACK_DATA && data == ctrl_word,
                    $sformatf("CTRL reads back %h, expected %h", data, ctrl_word));

        sent = 8'(next_random() >> 16);
        bus_write(UART_BASE + REG_WDATA, {24'd0, sent});
        check_tx_frame(sent);

        // Every byte sent comes back through the receiver.
        loopback <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            sent = 8'(next_random() >> 16);
            byte_q.push_back(sent);
            bus_write(UART_BASE + REG_WDATA, {24'd0, sent});
        end
        for (int i = 0; i < 8; i++) begin
            expected = byte_q.pop_front();
            bus_read(UART_BASE + REG_RDATA, op, data);
            expect_true(op == OP_ACK_DATA && data == {24'd0, expected},
                        $sformatf("loopback byte %0d is %h, expected %h", i, data, expected));
        end
        loopback <= 1'b0;

        bus_write(UART_BASE + REG_CTRL, {16'(baud_div), 14'd0, 1'b0, 1'b1});
        send_frame(8'(next_random() >> 16));
        bus_read(UART_BASE + REG_STATUS, op, data);
        expect_true(data[ST_RX_EMPTY], "a byte was stored while rx_en was clear");
        bus_write(UART_BASE + REG_CTRL, ctrl_word);
        sent = 8'(next_random() >> 16);
        send_frame(sent);
        bus_read(UART_BASE + REG_STATUS, op, data);
        expect_true(!data[ST_RX_EMPTY], "no byte was stored while rx_en was set");
        bus_read(UART_BASE + REG_RDATA, op, data);
        expect_true(op == OP_ACK_DATA && data == {24'd0, sent},
                    $sformatf("received byte is %h, expected %h", data, sent));

        bus_read(32'h3000_0000, op, data);
        expect_true(op == OP_ERR, $sformatf("unmapped address answered with opcode %0d", op));
        bus_read(UART_BASE + 32'h2, op, data);
        expect_true(op == OP_ERR, $sformatf("unmapped offset answered with opcode %0d", op));
        stalled_read(UART_BASE | 32'h100);

        repeat (5) @(posedge clk_i);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/uart_ctrl.sv
`default_nettype none

module uart_ctrl
    import bus_pkg::*;
    import uart_reg_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              req_valid_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_data_i,
    input  logic [OP_W-1:0]   req_op_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_data_o,
    output logic [OP_W-1:0]   rsp_op_o,
    input  logic              rsp_ready_i,
    input  logic              rx_i,
    output logic              tx_o
);

    localparam logic [1:0] S_IDLE       = 2'd0;
    localparam logic [1:0] S_WAIT_DATA  = 2'd1;
    localparam logic [1:0] S_WAIT_SPACE = 2'd2;

    logic [1:0]        state_q, state_d;
    uart_ctrl_u        ctrl_q, ctrl_d;
    logic              rsp_valid_q, rsp_valid_d;
    logic [DATA_W-1:0] rsp_data_q, rsp_data_d;
    logic [OP_W-1:0]   rsp_op_q, rsp_op_d;
    logic [BYTE_W-1:0] hold_q, hold_d;

    logic              hit, is_read, is_write, req_fire;
    logic [ADDR_W-1:0] offset;
    logic [DATA_W-1:0] status;
    logic              tx_push, tx_pop, tx_full, tx_empty;
    logic [BYTE_W-1:0] tx_wdata, tx_rdata;
    logic              rx_push, rx_pop, rx_full, rx_empty;
    logic [BYTE_W-1:0] rx_rdata, rx_byte;
    logic              rx_valid;

    assign hit      = (req_addr_i & ~UART_MASK) == UART_BASE;
    assign offset   = req_addr_i & UART_MASK;
    assign is_read  = (req_op_i == OP_GET);
    assign is_write = (req_op_i == OP_PUT_FULL) || (req_op_i == OP_PUT_PART);

    // No new request while busy or while a response is stuck.
    assign req_ready_o = (state_q == S_IDLE) && !(rsp_valid_q && !rsp_ready_i);
    assign req_fire    = req_valid_i && req_ready_o;

    always_comb begin
        status              = '0;
        status[ST_TX_FULL]  = tx_full;
        status[ST_TX_EMPTY] = tx_empty;
        status[ST_RX_FULL]  = rx_full;
        status[ST_RX_EMPTY] = rx_empty;
    end

    always_comb begin
        state_d     = state_q;
        ctrl_d      = ctrl_q;
        rsp_valid_d = rsp_valid_q && !rsp_ready_i;
        rsp_data_d  = rsp_data_q;
        rsp_op_d    = rsp_op_q;
        hold_d      = hold_q;
        tx_push     = 1'b0;
        tx_wdata    = req_data_i[BYTE_W-1:0]; // Only the low byte is sent.
        rx_pop      = 1'b0;
        case (state_q)
            S_IDLE: if (req_fire) begin
                rsp_valid_d = 1'b1;
                rsp_op_d    = OP_ACK;
                rsp_data_d  = '0;
                if (!hit || !(is_read || is_write)) begin
                    rsp_op_d = OP_ERR;
                end else begin
                    case (offset)
                        REG_CTRL: begin
                            if (is_read) begin
                                rsp_op_d   = OP_ACK_DATA;
                                rsp_data_d = ctrl_q.raw;
                            end else begin
                                ctrl_d.raw = req_data_i;
                            end
                        end
                        REG_STATUS: if (is_read) begin
                            rsp_op_d   = OP_ACK_DATA;
                            rsp_data_d = status;
                        end
                        REG_RDATA: if (is_read) begin
                            if (rx_empty) begin
                                rsp_valid_d = 1'b0;
                                state_d     = S_WAIT_DATA;
                            end else begin
                                rx_pop     = 1'b1;
                                rsp_op_d   = OP_ACK_DATA;
                                rsp_data_d = DATA_W'(rx_rdata);
                            end
                        end
                        REG_WDATA: if (is_write) begin
                            if (tx_full) begin
                                hold_d  = req_data_i[BYTE_W-1:0];
                                state_d = S_WAIT_SPACE;
                            end else begin
                                tx_push = 1'b1;
                            end
                        end
                        default: rsp_op_d = OP_ERR;
                    endcase
                end
            end
            S_WAIT_DATA: if (!rx_empty) begin
                rx_pop      = 1'b1;
                rsp_valid_d = 1'b1;
                rsp_op_d    = OP_ACK_DATA;
                rsp_data_d  = DATA_W'(rx_rdata);
                state_d     = S_IDLE;
            end
            default: if (!tx_full) begin
                tx_push  = 1'b1;
                tx_wdata = hold_q;
                state_d  = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= S_IDLE;
            ctrl_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            ctrl_q      <= ctrl_d;
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_data_q <= rsp_data_d;
        rsp_op_q   <= rsp_op_d;
        hold_q     <= hold_d;
    end

    // Received bytes are dropped when disabled or when the FIFO is full.
    assign rx_push = rx_valid && ctrl_q.fields.rx_en && !rx_full;

    sync_fifo #(.WIDTH(BYTE_W), .DEPTH(FIFO_DEPTH)) rx_buffer (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (rx_push),
        .wdata_i (rx_byte),
        .pop_i   (rx_pop),
        .rdata_o (rx_rdata),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

    sync_fifo #(.WIDTH(BYTE_W), .DEPTH(FIFO_DEPTH)) tx_buffer (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (tx_push),
        .wdata_i (tx_wdata),
        .pop_i   (tx_pop),
        .rdata_o (tx_rdata),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    uart_rx uart_rx_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rx_i         (rx_i),
        .baud_div_i   (ctrl_q.fields.baud_div),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .tx_en_i    (ctrl_q.fields.tx_en),
        .avail_i    (!tx_empty),
        .byte_i     (tx_rdata),
        .baud_div_i (ctrl_q.fields.baud_div),
        .pop_o      (tx_pop),
        .tx_o       (tx_o)
    );

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;
    assign rsp_op_o    = rsp_op_q;

    // A stalled response must not change until the master takes it.
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_op_o));

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`default_nettype none

module uart_tx
    import uart_reg_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              tx_en_i,
    input  logic              avail_i,
    input  logic [BYTE_W-1:0] byte_i,
    input  logic [15:0]       baud_div_i,
    output logic              pop_o,
    output logic              tx_o
);

    localparam logic S_IDLE = 1'b0;
    localparam logic S_SEND = 1'b1;

    logic              state_q;
    logic [15:0]       cnt_q;
    logic [3:0]        bit_q;
    logic [BYTE_W+1:0] frame_q;
    logic              bit_done;
    logic              frame_done;

    assign bit_done   = (cnt_q == baud_div_i - 16'd1);
    assign frame_done = bit_done && (bit_q == 4'd9);

    // Load in idle, or back to back at the end of the stop bit.
    assign pop_o = tx_en_i && avail_i && ((state_q == S_IDLE) || frame_done);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else if (pop_o) begin
            state_q <= S_SEND;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else if (state_q == S_SEND) begin
            if (frame_done) begin
                state_q <= S_IDLE;
            end else if (bit_done) begin
                cnt_q <= '0;
                bit_q <= bit_q + 4'd1;
            end else begin
                cnt_q <= cnt_q + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            frame_q <= {1'b1, byte_i, 1'b0}; // Stop, data LSB first, start.
        end else if (bit_done) begin
            frame_q <= {1'b1, frame_q[BYTE_W+1:1]};
        end
    end

    assign tx_o = (state_q == S_SEND) ? frame_q[0] : 1'b1;

    // Every loaded byte opens its frame with a low start bit on the next cycle.
    a_start_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_o |=> (state_q == S_SEND) && !tx_o);

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`default_nettype none

module uart_rx
    import uart_reg_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              rx_i,
    input  logic [15:0]       baud_div_i,
    output logic [BYTE_W-1:0] byte_o,
    output logic              byte_valid_o
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]        sync_q;
    logic              rx_s;
    logic [1:0]        state_q;
    logic [15:0]       cnt_q;
    logic [2:0]        bit_q;
    logic [BYTE_W-1:0] shift_q;
    logic              valid_q;
    logic              half_done;
    logic              bit_done;

    assign rx_s      = sync_q[1];
    assign half_done = (cnt_q == (baud_div_i >> 1) - 16'd1);
    assign bit_done  = (cnt_q == baud_div_i - 16'd1); // One full period from the last sample.

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sync_q  <= 2'b11; // Line idles high.
            state_q <= S_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], rx_i};
            valid_q <= 1'b0;
            cnt_q   <= cnt_q + 16'd1;
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_s) begin
                        state_q <= S_START;
                    end
                end
                S_START: if (half_done) begin
                    // A glitch shorter than half a bit sends us back to idle.
                    cnt_q   <= '0;
                    bit_q   <= '0;
                    state_q <= rx_s ? S_IDLE : S_DATA;
                end
                S_DATA: if (bit_done) begin
                    cnt_q   <= '0;
                    shift_q <= {rx_s, shift_q[BYTE_W-1:1]};
                    bit_q   <= bit_q + 3'd1;
                    if (bit_q == 3'd7) begin
                        state_q <= S_STOP;
                    end
                end
                default: if (bit_done) begin
                    valid_q <= rx_s; // A low stop bit drops the frame.
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    assign byte_o       = shift_q;
    assign byte_valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`default_nettype none

module sync_fifo
    import uart_reg_pkg::*;
#(
    parameter int WIDTH = BYTE_W,
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] rdata_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    assign rdata_o = mem[rd_ptr]; // Head of the queue is always visible.
    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i) !(push_i && full_o));
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn_i) !(pop_i && empty_o));

endmodule

`default_nettype wire

// File: design/uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

    localparam logic [31:0] UART_BASE = 32'h2000_0000;
    localparam logic [31:0] UART_MASK = 32'h0000_000F;

    localparam logic [31:0] REG_CTRL   = 32'h0;
    localparam logic [31:0] REG_STATUS = 32'h4;
    localparam logic [31:0] REG_RDATA  = 32'h8;
    localparam logic [31:0] REG_WDATA  = 32'hC;

    localparam int FIFO_DEPTH = 32;
    localparam int BYTE_W     = 8;

    // Bit positions inside the STATUS word.
    localparam int ST_TX_FULL  = 0;
    localparam int ST_TX_EMPTY = 1;
    localparam int ST_RX_FULL  = 2;
    localparam int ST_RX_EMPTY = 3;

    // CTRL is written and read back as one word but used by its fields.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] baud_div;
            logic [13:0] reserved;
            logic        rx_en;
            logic        tx_en;
        } fields;
    } uart_ctrl_u;

endpackage

`default_nettype wire

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int OP_W   = 3;

    // Request opcodes on the A channel.
    localparam logic [OP_W-1:0] OP_GET      = 3'd4;
    localparam logic [OP_W-1:0] OP_PUT_FULL = 3'd0;
    localparam logic [OP_W-1:0] OP_PUT_PART = 3'd1;

    // Response opcodes on the D channel.
    localparam logic [OP_W-1:0] OP_ACK      = 3'd0;
    localparam logic [OP_W-1:0] OP_ACK_DATA = 3'd1;
    localparam logic [OP_W-1:0] OP_ERR      = 3'd7; // Not part of the base protocol.

endpackage

`default_nettype wire
